// File: verilog.f
src/ctrl_pkg.sv
src/ctrl_decode.sv
src/uart_tx.sv
src/ms_timer.sv
src/spi_master.sv
src/ctrl_regs.sv
testbench/ctrl_regs_tb.sv

// File: Bender.yml
package:
  name: ctrl_regs

dependencies: {}

sources:
  # package first, top level last
  - src/ctrl_pkg.sv
  - src/ctrl_decode.sv
  - src/uart_tx.sv
  - src/ms_timer.sv
  - src/spi_master.sv
  - src/ctrl_regs.sv

  # simulation only
  - target: test
    files:
      - testbench/ctrl_regs_tb.sv

// File: testbench/ctrl_regs_tb.sv
`timescale 1ns/1ps

module ctrl_regs_tb;

  import ctrl_pkg::*;

  // two uart frames 8680, one timer tick 50000, spi and register traffic, margin
  localparam int max_cycles = 80000;

  logic           clk;
  logic           rst;
  logic [qaw-1:0] adr;
  logic           cs;
  logic           we;
  logic [qsw-1:0] sel;
  logic [qdw-1:0] dat_w;
  logic [qdw-1:0] dat_r;
  logic           ack;
  logic           err;
  logic           sys_rst;
  logic           core_rst;
  logic           uart_txd;
  logic [3:0]     spi_cs_n;
  logic           spi_clk;
  logic           spi_do;
  logic           spi_di;

  int          errors;
  int          cycles;
  // uart line monitor
  logic [7:0]  uart_q[$];
  logic        frame_on;
  int          frames_seen;
  logic [9:0]  frame;
  int          bit_i;
  // spi slave model
  logic [7:0]  slave_sr;
  logic [7:0]  slave_rx;
  int          sclk_rises;
  // test scratch
  logic [3:0]  cs_state;
  logic [31:0] rd;
  logic [7:0]  tx_b;
  logic [7:0]  sl_b;
  logic [15:0] t_val;

  ctrl_regs ctrl_regs_i (
    .clk      (clk),
    .rst      (rst),
    .adr      (adr),
    .cs       (cs),
    .we       (we),
    .sel      (sel),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .err      (err),
    .sys_rst  (sys_rst),
    .core_rst (core_rst),
    .uart_txd (uart_txd),
    .spi_cs_n (spi_cs_n),
    .spi_clk  (spi_clk),
    .spi_do   (spi_do),
    .spi_di   (spi_di)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("errors: %0d", errors);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_err_low : assert property (@(posedge clk) !err)
    else begin
      errors++;
      $display("ERR %0t err exp 0 got %b", $time, $sampled(err));
    end

  // plain registers ack in the request cycle
  a_ack_cs : assert property (@(posedge clk) disable iff (rst)
    (adr[4:2] != reg_uart_tx && adr[4:2] != reg_spi_dat) |-> ack == cs)
    else begin
      errors++;
      $display("ERR %0t ack exp %b got %b", $time, $sampled(cs), $sampled(ack));
    end

  // no uart write accepted while a frame is on the line
  a_uart_hold : assert property (@(posedge clk) disable iff (rst)
    (cs && adr[4:2] == reg_uart_tx && frame_on) |-> !ack)
    else begin
      errors++;
      $display("ERR %0t ack exp 0 got %b", $time, $sampled(ack));
    end

  // spi clock moves only while the data register holds off the bus
  a_spi_hold : assert property (@(posedge clk) disable iff (rst)
    (cs && adr[4:2] == reg_spi_dat && $changed(spi_clk)) |-> !ack)
    else begin
      errors++;
      $display("ERR %0t ack exp 0 got %b", $time, $sampled(ack));
    end

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus master, all tasks start and end 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task write_reg(input logic [2:0] idx, input logic [31:0] data);
    adr   = {{(qaw - 5){1'b0}}, idx, 2'b00};
    cs    = 1'b1;
    we    = 1'b1;
    dat_w = data;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    @(posedge clk);
    #1;
    cs = 1'b0;
    we = 1'b0;
  endtask

  // dat_r follows the registered address
  task read_reg(input logic [2:0] idx, output logic [31:0] data);
    adr = {{(qaw - 5){1'b0}}, idx, 2'b00};
    cs  = 1'b1;
    we  = 1'b0;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    @(posedge clk);
    #1;
    cs = 1'b0;
    @(negedge clk);
    data = dat_r;
    @(posedge clk);
    #1;
  endtask

  // idle peripheral must ack at once
  task expect_ack_now(input logic [2:0] idx);
    adr = {{(qaw - 5){1'b0}}, idx, 2'b00};
    cs  = 1'b1;
    we  = 1'b0;
    @(negedge clk);
    check_value("ack", ack, 1);
    @(posedge clk);
    #1;
    cs = 1'b0;
  endtask

  // mask nonzero updates only the masked lines, 1 means asserted
  function automatic logic [3:0] predict_cs(input logic [3:0] cur, input logic [7:0] w);
    if (w[7:4] != 4'd0) begin
      return (cur & ~w[7:4]) | (w[3:0] & w[7:4]);
    end
    return w[3:0];
  endfunction

  task write_cs(input logic [7:0] w);
    write_reg(reg_spi_cs, {24'h0, w});
    cs_state = predict_cs(cs_state, w);
    check_value("spi_cs_n", spi_cs_n, {28'h0, ~cs_state});
  endtask

  ////////////////////////////////////////////////////////////
  // uart monitor and spi slave
  ////////////////////////////////////////////////////////////

  // mid bit sampling of each 8n1 frame
  always begin
    @(negedge clk);
    if (!rst && uart_txd === 1'b0) begin
      frame_on = 1'b1;
      if (uart_q.size() == 0) begin
        errors++;
        $display("uart frame started at %0t with no byte written", $time);
        frame = 10'h3fe;
      end else begin
        frame = {1'b1, uart_q.pop_front(), 1'b0};
      end
      repeat (txd_cnt / 2) @(negedge clk);
      for (bit_i = 0; bit_i < 10; bit_i++) begin
        assert (uart_txd === frame[bit_i]) else begin
          errors++;
          $display("ERR %0t uart_txd exp %b got %b", $time, frame[bit_i], uart_txd);
        end
        if (bit_i < 9) begin
          repeat (txd_cnt) @(negedge clk);
        end
      end
      frame_on = 1'b0;
      frames_seen++;
    end
  end

  // mode 3 slave, drive on falling, capture on rising
  always @(negedge spi_clk) begin
    spi_di   <= slave_sr[7];
    slave_sr <= {slave_sr[6:0], 1'b0};
  end

  always @(posedge spi_clk) begin
    slave_rx   <= {slave_rx[6:0], spi_do};
    sclk_rises <= sclk_rises + 1;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h657cacb9));
    errors      = 0;
    cycles      = 0;
    frame_on    = 1'b0;
    frames_seen = 0;
    sclk_rises  = 0;
    slave_sr    = 8'h00;
    slave_rx    = 8'h00;
    cs_state    = 4'h0;
    clk         = 1'b0;
    rst         = 1'b1;
    adr         = '0;
    cs          = 1'b0;
    we          = 1'b0;
    sel         = '1;
    dat_w       = '0;
    spi_di      = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // reset state
    check_value("sys_rst", sys_rst, 0);
    check_value("core_rst", core_rst, 1);
    check_value("spi_cs_n", spi_cs_n, 32'hf);
    check_value("uart_txd", uart_txd, 1);
    check_value("spi_clk", spi_clk, 1);
    expect_ack_now(reg_uart_tx);
    expect_ack_now(reg_spi_dat);

    // reset levels take bit 0
    write_reg(reg_sys_rst, 32'h1);
    check_value("sys_rst", sys_rst, 1);
    write_reg(reg_core_rst, 32'hffff_fffe);
    check_value("core_rst", core_rst, 0);
    write_reg(reg_sys_rst, 32'h2);
    check_value("sys_rst", sys_rst, 0);
    write_reg(reg_core_rst, 32'h3);
    check_value("core_rst", core_rst, 1);

    // chip selects, unmasked and masked
    write_cs(8'h01);
    write_cs(8'h2f);
    write_cs(8'h10);
    write_cs(8'hc5);
    repeat (8) write_cs($urandom);
    write_cs(8'h00);

    // unmapped and write only registers read zero
    read_reg(3'd7, rd);
    check_value("dat_r", rd, 0);
    read_reg(reg_uart_tx, rd);
    check_value("dat_r", rd, 0);
    read_reg(reg_spi_cs, rd);
    check_value("dat_r", rd, 0);

    // one spi byte each way at divider 2
    write_cs(8'h01);
    write_reg(reg_spi_div, 32'd2);
    sl_b       = $urandom;
    tx_b       = $urandom;
    slave_sr   = sl_b;
    slave_rx   = 8'h00;
    sclk_rises = 0;
    write_reg(reg_spi_dat, {24'h0, tx_b});
    read_reg(reg_spi_dat, rd);
    check_value("dat_r", rd, {24'h0, sl_b});
    check_value("spi_do", {24'h0, slave_rx}, {24'h0, tx_b});
    check_value("spi_clk rises", sclk_rises, 8);
    write_cs(8'h10);

    // second byte waits for the first frame
    repeat (2) begin
      tx_b = $urandom;
      uart_q.push_back(tx_b);
      write_reg(reg_uart_tx, {24'h0, tx_b});
    end
    wait (frames_seen == 2);
    @(posedge clk);
    #1;

    // load, then one millisecond tick
    t_val = $urandom;
    write_reg(reg_timer, {16'h0, t_val});
    read_reg(reg_timer, rd);
    check_value("dat_r", rd, {16'h0, t_val});
    repeat (int'(timer_cnt) + 10) @(posedge clk);
    #1;
    read_reg(reg_timer, rd);
    check_value("dat_r", rd, {16'h0, t_val + 16'd1});

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                     clk,
  input  logic                     rst,
  // qmem bus
  input  logic [ctrl_pkg::qaw-1:0] adr,
  input  logic                     cs,
  input  logic                     we,
  input  logic [ctrl_pkg::qsw-1:0] sel,
  input  logic [ctrl_pkg::qdw-1:0] dat_w,
  output logic [ctrl_pkg::qdw-1:0] dat_r,
  output logic                     ack,
  output logic                     err,
  // reset levels
  output logic                     sys_rst,
  output logic                     core_rst,
  // serial ports
  output logic                     uart_txd,
  output logic [3:0]               spi_cs_n,
  output logic                     spi_clk,
  output logic                     spi_do,
  input  logic                     spi_di
);

  import ctrl_pkg::*;

  qmem_req_t   req;
  wr_stb_t     stb;
  periph_sts_t sts;
  logic        tx_ready;
  logic        spi_busy;
  logic [15:0] timer_val;
  logic [7:0]  spi_rx;

  // concatenation order follows the struct fields
  assign req = {adr, cs, we, sel, dat_w};
  assign sts = '{tx_ready: tx_ready, spi_busy: spi_busy};

  ////////////////////////////////////////////////////////////
  // decoder and peripherals
  ////////////////////////////////////////////////////////////

  ctrl_decode ctrl_decode_i (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .sts       (sts),
    .timer_val (timer_val),
    .spi_rx    (spi_rx),
    .stb       (stb),
    .sys_rst   (sys_rst),
    .core_rst  (core_rst),
    .spi_cs_n  (spi_cs_n),
    .dat_r     (dat_r),
    .ack       (ack),
    .err       (err)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst      (rst),
    .start    (stb.uart_tx),
    .tx_byte  (req.dat_w.byte_view.data),
    .tx_ready (tx_ready),
    .txd      (uart_txd)
  );

  // load value is the low half of the write word
  ms_timer ms_timer_i (
    .clk      (clk),
    .rst      (rst),
    .load     (stb.timer),
    .load_val (req.dat_w[15:0]),
    .count    (timer_val)
  );

  spi_master spi_master_i (
    .clk     (clk),
    .rst     (rst),
    .div_wr  (stb.spi_div),
    .dat_wr  (stb.spi_dat),
    .wdata   (req.dat_w.byte_view.data),
    .busy    (spi_busy),
    .rx_byte (spi_rx),
    .sclk    (spi_clk),
    .mosi    (spi_do),
    .miso    (spi_di)
  );

endmodule

// File: src/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic       clk,
  input  logic       rst,
  input  logic       div_wr,
  input  logic       dat_wr,
  input  logic [7:0] wdata,
  output logic       busy,
  output logic [7:0] rx_byte,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  import ctrl_pkg::*;

  // mode 3, cpol=1 cpha=1
  // mosi changes on falling sclk, miso sampled on rising sclk

  logic [5:0] div_r;
  logic [5:0] div_ctr;
  // half period index, sclk is its lsb
  logic [3:0] ph_cnt;
  logic       act;
  // extra high half period after the last rising edge
  logic       tail;
  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  logic       half_end;

  assign half_end = (div_ctr == 6'd0);
  assign busy     = act || tail;

  ////////////////////////////////////////////////////////////
  // divider register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_r <= spi_cnt;
    end else if (div_wr) begin
      div_r <= wdata[5:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // transfer sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      act     <= 1'b0;
      tail    <= 1'b0;
      div_ctr <= 6'd0;
      ph_cnt  <= 4'hf;
      tx_sr   <= 8'hff;
    end else if (act) begin
      if (half_end) begin
        div_ctr <= div_r;
        ph_cnt  <= ph_cnt - 4'd1;
        // sixteen half periods done
        if (ph_cnt == 4'd0) begin
          act  <= 1'b0;
          tail <= 1'b1;
        end
        // falling edge, first one keeps the msb
        if (ph_cnt[0] && (ph_cnt != 4'hf)) begin
          tx_sr <= {tx_sr[6:0], 1'b1};
        end
      end else begin
        div_ctr <= div_ctr - 6'd1;
      end
    end else if (tail) begin
      if (half_end) begin
        tail <= 1'b0;
      end else begin
        div_ctr <= div_ctr - 6'd1;
      end
    end else if (dat_wr) begin
      // strobe while busy falls through the branches above
      act     <= 1'b1;
      div_ctr <= div_r;
      ph_cnt  <= 4'hf;
      tx_sr   <= wdata;
    end
  end

  // receive shifter, capture on rising edge
  always_ff @(posedge clk) begin
    if (act && half_end && !ph_cnt[0]) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
  end

  assign sclk    = ph_cnt[0];
  assign mosi    = tx_sr[7];
  assign rx_byte = rx_sr;

  // clock parks high between transfers
  a_sclk_idle : assert property (@(posedge clk) disable iff (rst) !busy |-> sclk);

endmodule

// File: src/ms_timer.sv
`timescale 1ns/1ps

module ms_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic [15:0] load_val,
  output logic [15:0] count
);

  import ctrl_pkg::*;

  logic [15:0] pre;
  logic        tick;

  // last prescaler cycle of each millisecond
  assign tick = (pre == 16'd0);

  ////////////////////////////////////////////////////////////
  // prescaler and counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pre   <= timer_cnt - 16'd1;
      count <= 16'd0;
    end else if (load) begin
      // load restarts the millisecond
      pre   <= timer_cnt - 16'd1;
      count <= load_val;
    end else if (tick) begin
      pre   <= timer_cnt - 16'd1;
      // wraps at 16 bits
      count <= count + 16'd1;
    end else begin
      pre   <= pre - 16'd1;
    end
  end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       txd
);

  import ctrl_pkg::*;

  // 8n1 frame, bit 0 is on the line
  logic [9:0] tx_sr;
  // bits left after the current one
  logic [3:0] bit_cnt;
  // cycles left in the current bit
  logic [8:0] bit_tmr;

  ////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_sr   <= '1;
      bit_cnt <= 4'd0;
      bit_tmr <= 9'd0;
    end else if (start && tx_ready) begin
      // stop, data lsb first, start
      tx_sr   <= {1'b1, tx_byte, 1'b0};
      bit_cnt <= 4'd9;
      bit_tmr <= txd_cnt - 9'd1;
    end else if (bit_tmr != 9'd0) begin
      bit_tmr <= bit_tmr - 9'd1;
    end else if (bit_cnt != 4'd0) begin
      // next bit, idle ones fill from the top
      bit_cnt <= bit_cnt - 4'd1;
      bit_tmr <= txd_cnt - 9'd1;
      tx_sr   <= {1'b1, tx_sr[9:1]};
    end
  end

  // ready again in the last cycle of the stop bit
  assign tx_ready = (bit_cnt == 4'd0) && (bit_tmr == 9'd0);
  assign txd      = tx_sr[0];

  // line idles high between frames
  a_idle_high : assert property (@(posedge clk) disable iff (rst) tx_ready |-> txd);

endmodule

// File: src/ctrl_decode.sv
`timescale 1ns/1ps

module ctrl_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  ctrl_pkg::qmem_req_t      req,
  input  ctrl_pkg::periph_sts_t    sts,
  input  logic [15:0]              timer_val,
  input  logic [7:0]               spi_rx,
  output ctrl_pkg::wr_stb_t        stb,
  output logic                     sys_rst,
  output logic                     core_rst,
  output logic [3:0]               spi_cs_n,
  output logic [ctrl_pkg::qdw-1:0] dat_r,
  output logic                     ack,
  output logic                     err
);

  import ctrl_pkg::*;

  logic [2:0] reg_idx;
  logic [2:0] reg_idx_q;
  logic       wr;
  logic [3:0] cs_sel;

  // same field for strobes, register writes and ack
  assign reg_idx = req.adr[4:2];
  assign wr      = req.cs && req.we;

  ////////////////////////////////////////////////////////////
  // write strobes
  ////////////////////////////////////////////////////////////

  // busy peripherals drop their own strobe
  always_comb begin
    stb = '0;
    if (wr) begin
      case (reg_idx)
        reg_uart_tx: stb.uart_tx = 1'b1;
        reg_timer:   stb.timer   = 1'b1;
        reg_spi_div: stb.spi_div = 1'b1;
        reg_spi_dat: stb.spi_dat = 1'b1;
        default:     stb = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // local registers
  ////////////////////////////////////////////////////////////

  // masked update keeps unselected lines
  // a set bit in cs_sel asserts that line
  assign cs_sel = (|req.dat_w.cs_view.cs_mask) ?
                  ((req.dat_w.cs_view.cs_mask & req.dat_w.cs_view.cs_val) |
                   (~req.dat_w.cs_view.cs_mask & ~spi_cs_n)) :
                  req.dat_w.cs_view.cs_val;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sys_rst   <= 1'b0;
      core_rst  <= 1'b1;
      spi_cs_n  <= 4'b1111;
      reg_idx_q <= 3'd0;
    end else begin
      // read address for next cycle's dat_r
      reg_idx_q <= reg_idx;
      if (wr) begin
        case (reg_idx)
          reg_sys_rst:  sys_rst  <= req.dat_w[0];
          reg_core_rst: core_rst <= req.dat_w[0];
          reg_spi_cs:   spi_cs_n <= ~cs_sel;
          default:      ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux, ack and err
  ////////////////////////////////////////////////////////////

  // unmapped reads give zero
  always_comb begin
    case (reg_idx_q)
      reg_timer:   dat_r = {{(qdw - 16){1'b0}}, timer_val};
      reg_spi_dat: dat_r = {{(qdw - 8){1'b0}}, spi_rx};
      default:     dat_r = '0;
    endcase
  end

  // ack held low while the addressed peripheral is busy
  always_comb begin
    case (reg_idx)
      reg_uart_tx: ack = req.cs && sts.tx_ready;
      reg_spi_dat: ack = req.cs && !sts.spi_busy;
      default:     ack = req.cs;
    endcase
  end

  assign err = 1'b0;

  // an accepted data write turns the peripheral busy at the next edge
  a_uart_taken : assert property (@(posedge clk) disable iff (rst)
    (stb.uart_tx && ack) |=> !sts.tx_ready);
  a_spi_taken : assert property (@(posedge clk) disable iff (rst)
    (stb.spi_dat && ack) |=> sts.spi_busy);

endmodule

// File: src/ctrl_pkg.sv
package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////

  // qmem address, data and byte select widths
  localparam int qaw = 22;
  localparam int qdw = 32;
  localparam int qsw = qdw / 8;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // index taken from adr[4:2]
  localparam logic [2:0] reg_sys_rst  = 3'd0;
  localparam logic [2:0] reg_core_rst = 3'd1;
  localparam logic [2:0] reg_uart_tx  = 3'd2;
  localparam logic [2:0] reg_timer    = 3'd3;
  localparam logic [2:0] reg_spi_div  = 3'd4;
  localparam logic [2:0] reg_spi_cs   = 3'd5;
  localparam logic [2:0] reg_spi_dat  = 3'd6;

  // 115200 baud from a 50 MHz clock
  localparam logic [8:0]  txd_cnt   = 9'd434;
  // 1 ms tick from a 50 MHz clock
  localparam logic [15:0] timer_cnt = 16'd50000;
  // slow sd card init clock after reset
  localparam logic [5:0]  spi_cnt   = 6'd63;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // write word seen as a single data byte
  typedef struct packed {
    logic [qdw-9:0] pad;
    logic [7:0]     data;
  } wbyte_t;

  // write word seen as chip select mask and value
  typedef struct packed {
    logic [qdw-9:0] pad;
    logic [3:0]     cs_mask;
    logic [3:0]     cs_val;
  } wcs_t;

  typedef union packed {
    wbyte_t byte_view;
    wcs_t   cs_view;
  } wdata_u;

  // one bus request as seen by the decoder
  typedef struct packed {
    logic [qaw-1:0] adr;
    logic           cs;
    logic           we;
    logic [qsw-1:0] sel;
    wdata_u         dat_w;
  } qmem_req_t;

  // single cycle write pulses
  typedef struct packed {
    logic uart_tx;
    logic timer;
    logic spi_div;
    logic spi_dat;
  } wr_stb_t;

  typedef struct packed {
    logic tx_ready;
    logic spi_busy;
  } periph_sts_t;

endpackage
